// File: bench/frontend_tb.sv
`default_nettype none

module frontend_tb;
    import fetch_pkg::*;

    localparam int test_cycles = 1600;
    localparam int slack = 4;

    logic        clk;
    logic        reset;
    logic        bus_en;
    logic        accept_bit;
    redirect_t   branch;
    redirect_t   eret;
    logic        exception;
    logic        stall;
    ibus_req_t   ireq;
    ibus_resp_t  iresp;
    fetch_pair_t pair;

    logic [15:0] lfsr;
    int          errors;
    int          consumed;
    word_t       exp_pc;
    logic        exp_parked;
    fetch_pair_t held_pair;
    logic        held_valid;
    logic        prev_wait;
    word_t       prev_addr;

    fetch_frontend u_dut (
        .clk       (clk),
        .reset     (reset),
        .ireq      (ireq),
        .iresp     (iresp),
        .branch    (branch),
        .eret      (eret),
        .exception (exception),
        .stall     (stall),
        .pair      (pair)
    );

    ibus_model u_bus (
        .clk        (clk),
        .reset      (reset),
        .en         (bus_en),
        .accept_bit (accept_bit),
        .ireq       (ireq),
        .iresp      (iresp)
    );

    always #5 clk = ~clk;

    function automatic logic lfsr_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    always @(posedge clk) begin
        accept_bit <= lfsr_bit();
    end

    // target the DUT should pick, exception first
    function automatic word_t redirect_goal();
        if (exception) return exc_entry_pc;
        if (eret.valid) return eret.target;
        return branch.target;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // compare a consumed pair against the reference pc
    task automatic check_pair();
        logic mis;
        mis = |exp_pc[1:0];
        assert (!exp_parked) else begin
            errors++;
            $display("valid pair at %0t while fetch should be parked", $time);
        end
        check_field("pair.slot0.pc", pair.slot0.pc, exp_pc);
        expect_bit("pair.slot0.valid", pair.slot0.valid, 1'b1);
        expect_bit("pair.slot0.misaligned", pair.slot0.misaligned, mis);
        check_field("pair.slot0.instr", pair.slot0.instr, mis ? 32'd0 : ~exp_pc);
        expect_bit("pair.slot1.valid", pair.slot1.valid, !mis && !exp_pc[2]);
        if (!mis && !exp_pc[2]) begin
            check_field("pair.slot1.pc", pair.slot1.pc, exp_pc + 32'd4);
            check_field("pair.slot1.instr", pair.slot1.instr, ~(exp_pc + 32'd4));
            expect_bit("pair.slot1.misaligned", pair.slot1.misaligned, 1'b0);
        end
        if (mis) begin
            exp_parked = 1'b1;
        end else begin
            exp_pc = exp_pc[2] ? exp_pc + 32'd4 : exp_pc + 32'd8;
        end
        consumed++;
    endtask

    // outputs are sampled half a cycle after the inputs change
    always @(negedge clk) begin
        if (!reset) begin
            if (branch.valid || eret.valid || exception) begin
                exp_pc = redirect_goal();
                exp_parked = 1'b0;
                held_valid = 1'b0;
            end else if (stall && (pair.slot0.valid || pair.slot1.valid)) begin
                if (held_valid) begin
                    assert (pair == held_pair) else begin
                        errors++;
                        $display("pair changed at %0t during stall", $time);
                    end
                end
                // no new request while decode holds the pair
                expect_bit("ireq.valid", ireq.valid, 1'b0);
                held_pair = pair;
                held_valid = 1'b1;
            end else begin
                held_valid = 1'b0;
                if (pair.slot0.valid || pair.slot1.valid) begin
                    check_pair();
                end
            end
            if (exp_parked) begin
                expect_bit("ireq.valid", ireq.valid, 1'b0);
            end
            if (prev_wait && ireq.valid) begin
                check_field("ireq.addr", ireq.addr, prev_addr);
            end
            prev_wait = ireq.valid & ~iresp.addr_ok;
            prev_addr = ireq.addr;
        end
    end

    task automatic wait_pairs(input int n);
        int goal;
        goal = consumed + n;
        while (consumed < goal) begin
            @(posedge clk);
        end
    endtask

    task automatic pulse_redirect(input logic exc, input redirect_t er, input redirect_t br);
        @(posedge clk);
        exception <= exc;
        eret <= er;
        branch <= br;
        @(posedge clk);
        exception <= 1'b0;
        eret <= '0;
        branch <= '0;
    endtask

    task automatic reset_start();
        @(negedge clk);
        expect_bit("pair.slot0.valid", pair.slot0.valid, 1'b0);
        expect_bit("pair.slot1.valid", pair.slot1.valid, 1'b0);
        wait_pairs(1);
    endtask

    task automatic random_stream();
        wait_pairs(60);
    endtask

    task automatic stall_pulses();
        int len;
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            len = 1 + int'({lfsr_bit(), lfsr_bit(), lfsr_bit()});
            @(posedge clk);
            stall <= 1'b1;
            repeat (len) @(posedge clk);
            stall <= 1'b0;
            wait_pairs(2);
        end
    endtask

    task automatic branch_odd_target();
        pulse_redirect(1'b0, '0, '{valid: 1'b1, target: 32'h8000_1004});
        wait_pairs(5);
        // hold addr_ok low so the branch meets a waiting request
        @(posedge clk);
        bus_en <= 1'b0;
        @(negedge clk);
        while (!ireq.valid) @(negedge clk);
        pulse_redirect(1'b0, '0, '{valid: 1'b1, target: 32'h8000_2014});
        bus_en <= 1'b1;
        wait_pairs(5);
    endtask

    task automatic priority_order();
        pulse_redirect(1'b1, '{valid: 1'b1, target: 32'h8000_3000},
                       '{valid: 1'b1, target: 32'h8000_4000});
        wait_pairs(3);
        pulse_redirect(1'b0, '{valid: 1'b1, target: 32'h8000_3000},
                       '{valid: 1'b1, target: 32'h8000_4000});
        wait_pairs(3);
    endtask

    task automatic misaligned_park();
        pulse_redirect(1'b0, '0, '{valid: 1'b1, target: 32'h8000_5002});
        while (!exp_parked) @(posedge clk);
        // nothing may come out while parked
        repeat (20) @(posedge clk);
        pulse_redirect(1'b0, '0, '{valid: 1'b1, target: 32'h8000_6000});
        wait_pairs(4);
    endtask

    initial begin
        #(test_cycles * slack * 10);
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        bus_en = 1'b1;
        accept_bit = 1'b0;
        branch = '0;
        eret = '0;
        exception = 1'b0;
        stall = 1'b0;
        lfsr = 16'd4;
        errors = 0;
        consumed = 0;
        exp_pc = reset_pc;
        exp_parked = 1'b0;
        held_valid = 1'b0;
        prev_wait = 1'b0;
        prev_addr = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        reset_start();
        random_stream();
        stall_pulses();
        branch_odd_target();
        priority_order();
        misaligned_park();
        repeat (5) @(posedge clk);
        $display("errors: %0d, pairs checked: %0d", errors, consumed);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/ibus_model.sv
`default_nettype none

module ibus_model (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  en,
    input  logic                  accept_bit,
    input  fetch_pkg::ibus_req_t  ireq,
    output fetch_pkg::ibus_resp_t iresp
);
    import fetch_pkg::*;

    logic        data_ok;
    logic [63:0] data;

    // address accept comes from the random bit, gated by the enable
    assign iresp.addr_ok = en & accept_bit;
    assign iresp.data_ok = data_ok;
    assign iresp.data    = data;

    // instruction word at address a is the inverse of a
    always_ff @(posedge clk) begin
        if (reset) begin
            data_ok <= 1'b0;
            data    <= '0;
        end else if (ireq.valid && iresp.addr_ok) begin
            data_ok <= 1'b1;
            data    <= {~(ireq.addr + 32'd4), ~ireq.addr};
        end else begin
            data_ok <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: frontend.f
hdl/fetch_pkg.sv
hdl/pipe_reg.sv
hdl/pc_gen.sv
hdl/instr_capture.sv
hdl/fetch_frontend.sv
bench/ibus_model.sv
bench/frontend_tb.sv

// File: hdl/fetch_frontend.sv
`default_nettype none

module fetch_frontend (
    input  logic                   clk,
    input  logic                   reset,
    output fetch_pkg::ibus_req_t   ireq,
    input  fetch_pkg::ibus_resp_t  iresp,
    input  fetch_pkg::redirect_t   branch,
    input  fetch_pkg::redirect_t   eret,
    input  logic                   exception,
    input  logic                   stall,
    output fetch_pkg::fetch_pair_t pair
);
    import fetch_pkg::*;

    fetch1_t     f1_next;
    fetch1_t     f1;
    fetch_pair_t pair_next;
    logic        advance;
    logic        redirect;

    // hold only when decode stalls with something valid in front of it
    assign advance = ~(stall & (pair.slot0.valid | pair.slot1.valid));

    pc_gen u_pc_gen (
        .clk       (clk),
        .reset     (reset),
        .branch    (branch),
        .eret      (eret),
        .exception (exception),
        .iresp     (iresp),
        .advance   (advance),
        .ireq      (ireq),
        .f1_next   (f1_next),
        .redirect  (redirect)
    );

    pipe_reg #(.T(fetch1_t)) u_f1_reg (
        .clk   (clk),
        .reset (reset),
        .en    (advance),
        .flush (redirect),
        .in    (f1_next),
        .out   (f1)
    );

    instr_capture u_capture (
        .clk       (clk),
        .reset     (reset),
        .f1        (f1),
        .iresp     (iresp),
        .advance   (advance),
        .redirect  (redirect),
        .pair_next (pair_next)
    );

    pipe_reg #(.T(fetch_pair_t)) u_f2_reg (
        .clk   (clk),
        .reset (reset),
        .en    (advance),
        .flush (redirect),
        .in    (pair_next),
        .out   (pair)
    );

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] word_t;

    // first fetch after reset, and the exception vector
    localparam word_t reset_pc     = 32'hbfc0_0000;
    localparam word_t exc_entry_pc = 32'hbfc0_0380;

    // instruction bus, request side
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    // low word is the instruction at addr, high word at addr + 4
    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [63:0] data;
    } ibus_resp_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  misaligned;
    } fetch1_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
        logic  misaligned;
    } fetch_slot_t;

    // slot0 is first in program order
    typedef struct packed {
        fetch_slot_t slot0;
        fetch_slot_t slot1;
    } fetch_pair_t;

endpackage

`default_nettype wire

// File: hdl/instr_capture.sv
`default_nettype none

module instr_capture (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::fetch1_t    f1,
    input  fetch_pkg::ibus_resp_t iresp,
    input  logic                  advance,
    input  logic                  redirect,
    output fetch_pkg::fetch_pair_t pair_next
);
    import fetch_pkg::*;

    logic [63:0] saved_data;
    logic        saved_flag;
    logic [63:0] beat;
    logic        have_data;
    word_t       first_word;

    // beat arrived while the next stage was stalled
    always_ff @(posedge clk) begin
        if (reset || redirect || advance) begin
            saved_flag <= 1'b0;
        end else if (iresp.data_ok && f1.valid) begin
            saved_flag <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (iresp.data_ok && !advance) begin
            saved_data <= iresp.data;
        end
    end

    assign beat      = saved_flag ? saved_data : iresp.data;
    assign have_data = saved_flag | iresp.data_ok;

    // pc bit 2 picks the high word for slot 0
    assign first_word = f1.pc[2] ? beat[63:32] : beat[31:0];

    always_comb begin
        pair_next.slot0.valid      = f1.valid & (f1.misaligned | have_data);
        pair_next.slot0.pc         = f1.pc;
        pair_next.slot0.misaligned = f1.misaligned;
        if (f1.misaligned) begin
            pair_next.slot0.instr = '0;
        end else begin
            pair_next.slot0.instr = first_word;
        end
    end

    // second slot only for an aligned, good pc
    always_comb begin
        pair_next.slot1.valid      = f1.valid & ~f1.misaligned & ~f1.pc[2] & have_data;
        pair_next.slot1.pc         = f1.pc + 32'd4;
        pair_next.slot1.instr      = beat[63:32];
        pair_next.slot1.misaligned = 1'b0;
    end

endmodule

`default_nettype wire

// File: hdl/pc_gen.sv
`default_nettype none

module pc_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::redirect_t  branch,
    input  fetch_pkg::redirect_t  eret,
    input  logic                  exception,
    input  fetch_pkg::ibus_resp_t iresp,
    input  logic                  advance,
    output fetch_pkg::ibus_req_t  ireq,
    output fetch_pkg::fetch1_t    f1_next,
    output logic                  redirect
);
    import fetch_pkg::*;

    word_t pc;
    word_t pc_step;
    word_t redirect_target;
    word_t saved_target;
    word_t kill_target;
    logic  saved_valid;
    logic  pending;
    logic  parked;
    logic  misaligned;
    logic  accept;
    logic  waiting;
    logic  kill;
    logic  emit_misaligned;

    // exception, then eret, then branch
    always_comb begin
        if (exception) begin
            redirect_target = exc_entry_pc;
        end else if (eret.valid) begin
            redirect_target = eret.target;
        end else begin
            redirect_target = branch.target;
        end
    end

    assign redirect = exception | eret.valid | branch.valid;

    assign misaligned = |pc[1:0];

    // odd word yields one slot only
    assign pc_step = pc[2] ? pc + 32'd4 : pc + 32'd8;

    // a request already on the bus is kept up through a redirect
    assign ireq.valid = advance & ~parked & ~misaligned &
                        (pending | (~redirect & ~saved_valid));
    assign ireq.addr  = {pc[31:3], 3'b000};

    assign accept  = ireq.valid & iresp.addr_ok;
    assign waiting = ireq.valid & ~iresp.addr_ok;

    // accepted request belongs to the old path
    assign kill        = redirect | saved_valid;
    assign kill_target = redirect ? redirect_target : saved_target;

    assign emit_misaligned = misaligned & ~parked & advance & ~redirect & ~saved_valid;

    assign f1_next.valid      = (accept & ~kill) | emit_misaligned;
    assign f1_next.pc         = pc;
    assign f1_next.misaligned = misaligned;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= reset_pc;
            saved_valid <= 1'b0;
            pending     <= 1'b0;
            parked      <= 1'b0;
        end else if (accept) begin
            pending     <= 1'b0;
            saved_valid <= 1'b0;
            if (kill) begin
                pc <= kill_target;
            end else begin
                pc <= pc_step;
            end
        end else if (redirect && waiting) begin
            // defer until the bus takes the address
            pending     <= 1'b1;
            saved_valid <= 1'b1;
        end else if (redirect) begin
            pc          <= redirect_target;
            pending     <= 1'b0;
            saved_valid <= 1'b0;
            parked      <= 1'b0;
        end else begin
            if (waiting) begin
                pending <= 1'b1;
            end
            // stop after reporting the bad pc once
            if (emit_misaligned) begin
                parked <= 1'b1;
            end
        end
    end

    // later redirect overwrites an earlier one
    always_ff @(posedge clk) begin
        if (redirect && waiting) begin
            saved_target <= redirect_target;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic flush,
    input  T     in,
    output T     out
);

    // flush wins over a load in the same cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out <= '0;
        end else if (en) begin
            out <= in;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    -f frontend.f \
    --top-module frontend_tb \
    --Mdir "$build_dir" \
    -o frontend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile step returned status $status"
    exit 1
fi

"./$build_dir/frontend_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$log_file"; then
    exit 0
fi
exit 1
